// ==== include/icmp_tx_params.svh ====
`ifndef ICMP_TX_PARAMS_SVH
`define ICMP_TX_PARAMS_SVH

// payload datapath width
`define DATA_W 64

// one byte enable per payload byte
`define KEEP_W 8

`define BYTES_PER_WORD 8

// ICMP length field and IP total length
`define LEN_W 16

// 20 bytes IP header plus 8 bytes ICMP header
`define IP_ICMP_OVERHEAD 28

`endif

// ==== verilog/icmp_tx_pkg.sv ====
`default_nettype none

package icmp_tx_pkg;

`include "icmp_tx_params.svh"

    typedef logic [`DATA_W-1:0] data_word_t;
    typedef logic [`KEEP_W-1:0] keep_t;
    typedef logic [`LEN_W-1:0]  len_t;
    typedef logic [31:0]        ip_addr_t;
    typedef logic [3:0]         byte_count_t;

    typedef enum logic [1:0] {
        st_idle,
        st_write_header,
        st_write_payload,
        st_write_payload_last
    } tx_state_e;

    // number of contiguous low-order bytes enabled
    function automatic byte_count_t keep_to_count(input keep_t keep);
        byte_count_t count;
        logic        run;
        count = '0;
        run = 1'b1;
        for (int i = 0; i < `KEEP_W; i++) begin
            run = run & keep[i];
            if (run) begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

    function automatic keep_t count_to_keep(input byte_count_t count);
        keep_t keep;
        for (int i = 0; i < `KEEP_W; i++) begin
            keep[i] = (i < count);
        end
        return keep;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/icmp_hdr_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icmp_tx_params.svh"

module icmp_hdr_regs import icmp_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        store_hdr,
    input  logic [7:0]  icmp_type,
    input  logic [7:0]  icmp_code,
    input  logic [15:0] icmp_checksum,
    input  logic [31:0] icmp_rest,
    input  len_t        icmp_length,
    input  logic [15:0] ip_identification,
    input  logic [7:0]  ip_ttl,
    input  ip_addr_t    ip_source,
    input  ip_addr_t    ip_dest,
    input  logic        out_hdr_ready,
    output logic        out_hdr_valid,
    output logic        hdr_out_held,
    output len_t        out_ip_length,
    output logic [15:0] out_ip_identification,
    output logic [7:0]  out_ip_ttl,
    output ip_addr_t    out_ip_source,
    output ip_addr_t    out_ip_dest,
    output data_word_t  icmp_word,
    output len_t        word_count_init
);

    logic [7:0]  type_q;
    logic [7:0]  code_q;
    logic [15:0] checksum_q;
    logic [31:0] rest_q;

    // header still pending next cycle, either newly stored or not yet taken
    assign hdr_out_held = store_hdr || (out_hdr_valid && !out_hdr_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else begin
            out_hdr_valid <= hdr_out_held;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            out_ip_length         <= icmp_length + len_t'(`IP_ICMP_OVERHEAD);
            out_ip_identification <= ip_identification;
            out_ip_ttl            <= ip_ttl;
            out_ip_source         <= ip_source;
            out_ip_dest           <= ip_dest;
            word_count_init       <= icmp_length;
            type_q                <= icmp_type;
            code_q                <= icmp_code;
            checksum_q            <= icmp_checksum;
            rest_q                <= icmp_rest;
        end
    end

    // network byte order, first byte on the wire in bits 7:0
    assign icmp_word = {rest_q[7:0], rest_q[15:8], rest_q[23:16], rest_q[31:24],
                        checksum_q[7:0], checksum_q[15:8], code_q, type_q};

endmodule

`default_nettype wire

// ==== verilog/icmp_tx_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icmp_tx_params.svh"

module icmp_tx_fsm import icmp_tx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    output logic       store_hdr,
    input  logic       hdr_out_held,
    input  data_word_t icmp_word,
    input  len_t       word_count_init,
    input  data_word_t in_data,
    input  keep_t      in_keep,
    input  logic       in_valid,
    input  logic       in_last,
    input  logic       in_user,
    output logic       in_ready,
    output data_word_t buf_data,
    output keep_t      buf_keep,
    output logic       buf_valid,
    output logic       buf_last,
    output logic       buf_user,
    input  logic       buf_ready,
    input  logic       buf_ready_early,
    output logic       busy,
    output logic       early_end_error
);

    tx_state_e  state;
    tx_state_e  state_next;
    logic       hdr_ready_next;
    logic       in_ready_next;
    logic       error_next;
    logic       store_last;
    len_t       word_count;
    len_t       word_count_next;
    data_word_t last_data;
    keep_t      last_keep;

    always_comb begin
        state_next = state;
        hdr_ready_next = 1'b0;
        in_ready_next = 1'b0;
        store_hdr = 1'b0;
        store_last = 1'b0;
        error_next = 1'b0;
        word_count_next = word_count;
        buf_data = '0;
        buf_keep = '0;
        buf_valid = 1'b0;
        buf_last = 1'b0;
        buf_user = 1'b0;

        case (state)
            st_idle: begin
                // wait for previous output header to be taken
                hdr_ready_next = !hdr_out_held;
                if (hdr_ready && hdr_valid) begin
                    store_hdr = 1'b1;
                    hdr_ready_next = 1'b0;
                    state_next = st_write_header;
                end
            end
            st_write_header: begin
                word_count_next = word_count_init;
                if (buf_ready) begin
                    buf_valid = 1'b1;
                    buf_data = icmp_word;
                    buf_keep = '1;
                    in_ready_next = buf_ready_early;
                    state_next = st_write_payload;
                end
            end
            st_write_payload: begin
                in_ready_next = buf_ready_early;
                buf_data = in_data;
                buf_keep = in_keep;
                buf_last = in_last;
                buf_user = in_user;
                if (in_ready && in_valid) begin
                    word_count_next = word_count - len_t'(`BYTES_PER_WORD);
                    buf_valid = 1'b1;
                    if (word_count <= len_t'(`BYTES_PER_WORD)) begin
                        // declared length complete on this beat
                        buf_keep = count_to_keep(byte_count_t'(word_count));
                        if (in_last) begin
                            if (keep_to_count(in_keep) < byte_count_t'(word_count)) begin
                                error_next = 1'b1;
                                buf_user = 1'b1;
                            end
                            in_ready_next = 1'b0;
                            hdr_ready_next = !hdr_out_held;
                            state_next = st_idle;
                        end else begin
                            // hold trimmed beat until input frame ends
                            buf_valid = 1'b0;
                            store_last = 1'b1;
                            state_next = st_write_payload_last;
                        end
                    end else if (in_last) begin
                        // input ended before declared length
                        error_next = 1'b1;
                        buf_user = 1'b1;
                        in_ready_next = 1'b0;
                        hdr_ready_next = !hdr_out_held;
                        state_next = st_idle;
                    end
                end
            end
            st_write_payload_last: begin
                // discard surplus beats
                in_ready_next = buf_ready_early;
                buf_data = last_data;
                buf_keep = last_keep;
                buf_last = in_last;
                buf_user = in_user;
                if (in_ready && in_valid && in_last) begin
                    buf_valid = 1'b1;
                    in_ready_next = 1'b0;
                    hdr_ready_next = !hdr_out_held;
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            hdr_ready <= 1'b0;
            in_ready <= 1'b0;
            busy <= 1'b0;
            early_end_error <= 1'b0;
        end else begin
            state <= state_next;
            hdr_ready <= hdr_ready_next;
            in_ready <= in_ready_next;
            busy <= (state_next != st_idle);
            early_end_error <= error_next;
        end
    end

    always_ff @(posedge clk) begin
        word_count <= word_count_next;
        if (store_last) begin
            last_data <= buf_data;
            last_keep <= buf_keep;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axis_out_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_out_buffer import icmp_tx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  data_word_t buf_data,
    input  keep_t      buf_keep,
    input  logic       buf_valid,
    input  logic       buf_last,
    input  logic       buf_user,
    output logic       buf_ready,
    output logic       buf_ready_early,
    output data_word_t out_data,
    output keep_t      out_keep,
    output logic       out_valid,
    output logic       out_last,
    output logic       out_user,
    input  logic       out_ready
);

    data_word_t temp_data;
    keep_t      temp_keep;
    logic       temp_valid;
    logic       temp_last;
    logic       temp_user;
    logic       out_valid_next;
    logic       temp_valid_next;
    logic       load_out;
    logic       load_temp;
    logic       temp_to_out;

    // accept next cycle if output drains or nothing is held
    assign buf_ready_early = out_ready || (!temp_valid && !out_valid);

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        load_out = 1'b0;
        load_temp = 1'b0;
        temp_to_out = 1'b0;

        if (buf_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = buf_valid;
                load_out = 1'b1;
            end else begin
                // output stalled, park beat in temp
                temp_valid_next = buf_valid;
                load_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            buf_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            buf_ready <= buf_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= buf_data;
            out_keep <= buf_keep;
            out_last <= buf_last;
            out_user <= buf_user;
        end else if (temp_to_out) begin
            out_data <= temp_data;
            out_keep <= temp_keep;
            out_last <= temp_last;
            out_user <= temp_user;
        end
        if (load_temp) begin
            temp_data <= buf_data;
            temp_keep <= buf_keep;
            temp_last <= buf_last;
            temp_user <= buf_user;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icmp_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module icmp_tx_top import icmp_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // header input
    input  logic        hdr_valid,
    output logic        hdr_ready,
    input  logic [7:0]  icmp_type,
    input  logic [7:0]  icmp_code,
    input  logic [15:0] icmp_checksum,
    input  logic [31:0] icmp_rest,
    input  len_t        icmp_length,
    input  logic [15:0] ip_identification,
    input  logic [7:0]  ip_ttl,
    input  ip_addr_t    ip_source,
    input  ip_addr_t    ip_dest,
    // payload input
    input  data_word_t  in_data,
    input  keep_t       in_keep,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        in_last,
    input  logic        in_user,
    // IP header output
    output logic        out_hdr_valid,
    input  logic        out_hdr_ready,
    output len_t        out_ip_length,
    output logic [15:0] out_ip_identification,
    output logic [7:0]  out_ip_ttl,
    output ip_addr_t    out_ip_source,
    output ip_addr_t    out_ip_dest,
    // IP payload output
    output data_word_t  out_data,
    output keep_t       out_keep,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        out_last,
    output logic        out_user,
    output logic        busy,
    output logic        early_end_error
);

    logic       store_hdr;
    logic       hdr_out_held;
    data_word_t icmp_word;
    len_t       word_count_init;
    data_word_t buf_data;
    keep_t      buf_keep;
    logic       buf_valid;
    logic       buf_last;
    logic       buf_user;
    logic       buf_ready;
    logic       buf_ready_early;

    icmp_hdr_regs u_hdr_regs (.*);

    icmp_tx_fsm u_fsm (.*);

    axis_out_buffer u_out_buffer (.*);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period = 5;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release reset away from the rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_icmp_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icmp_tx_params.svh"

module tb_icmp_tx
    import icmp_tx_pkg::*;
();

    typedef struct packed {
        logic [7:0]  icmp_type;
        logic [7:0]  icmp_code;
        logic [15:0] icmp_checksum;
        logic [31:0] icmp_rest;
        len_t        length;
        logic [15:0] ident;
        logic [7:0]  ttl;
        ip_addr_t    source;
        ip_addr_t    dest;
        int          n_beats;
        logic        stall;
    } row_t;

    localparam int num_rows = 7;

    logic        clk;
    logic        rst;
    logic        hdr_valid;
    logic        hdr_ready;
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_checksum;
    logic [31:0] icmp_rest;
    len_t        icmp_length;
    logic [15:0] ip_identification;
    logic [7:0]  ip_ttl;
    ip_addr_t    ip_source;
    ip_addr_t    ip_dest;
    data_word_t  in_data;
    keep_t       in_keep;
    logic        in_valid;
    logic        in_ready;
    logic        in_last;
    logic        in_user;
    logic        out_hdr_valid;
    logic        out_hdr_ready;
    len_t        out_ip_length;
    logic [15:0] out_ip_identification;
    logic [7:0]  out_ip_ttl;
    ip_addr_t    out_ip_source;
    ip_addr_t    out_ip_dest;
    data_word_t  out_data;
    keep_t       out_keep;
    logic        out_valid;
    logic        out_ready;
    logic        out_last;
    logic        out_user;
    logic        busy;
    logic        early_end_error;

    integer      seed;
    logic        table_ready = 1'b0;
    row_t        rows [num_rows];
    data_word_t  exp_data [$];
    keep_t       exp_keep [$];
    logic        exp_last [$];
    logic        exp_user [$];
    int          exp_errors;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    icmp_tx_top DUT (.*);

    task automatic fill_table();
        // type, code, checksum, rest, length, ident, ttl, source, dest, beats, stall
        rows[0] = '{8'h08, 8'h00, 16'hf7fd, 32'h1234_0001, 16'd24, 16'h1001, 8'd64,
                    32'hc0a8_0001, 32'hc0a8_0002, 3, 1'b0};
        // partial last beat
        rows[1] = '{8'h00, 8'h00, 16'h1a2b, 32'h5678_000a, 16'd21, 16'h2002, 8'd128,
                    32'h0a00_0001, 32'h0a00_00fe, 3, 1'b0};
        // surplus input beats
        rows[2] = '{8'h08, 8'h00, 16'hbeef, 32'h0001_0002, 16'd13, 16'h3003, 8'd32,
                    32'hac10_0005, 32'hac10_0006, 5, 1'b0};
        // input ends two beats short
        rows[3] = '{8'h03, 8'h01, 16'hcafe, 32'h0000_0000, 16'd30, 16'h4004, 8'd255,
                    32'h7f00_0001, 32'h7f00_0002, 2, 1'b0};
        // same shapes again under output stalls
        rows[4] = '{8'h08, 8'h00, 16'h0bad, 32'h0002_0003, 16'd21, 16'h5005, 8'd17,
                    32'hc0a8_0103, 32'hc0a8_0104, 3, 1'b1};
        rows[5] = '{8'h00, 8'h00, 16'h5555, 32'h0003_0004, 16'd40, 16'h6006, 8'd9,
                    32'h0a01_0203, 32'h0a04_0506, 7, 1'b1};
        rows[6] = '{8'h0b, 8'h00, 16'haaaa, 32'h0004_0005, 16'd19, 16'h7007, 8'd1,
                    32'hac1f_0001, 32'hac1f_0002, 1, 1'b1};
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    // first n bytes enabled
    function automatic keep_t low_bytes(input int n);
        return keep_t'((16'd1 << n) - 16'd1);
    endfunction

    function automatic data_word_t payload_word(input int r, input int beat);
        data_word_t w;
        for (int b = 0; b < `BYTES_PER_WORD; b++) begin
            w[b*8 +: 8] = 8'(r * 37 + beat * 8 + b + 1);
        end
        return w;
    endfunction

    // full beats except where the declared length ends inside a beat
    function automatic keep_t input_keep(input len_t length, input int beat);
        int tail;
        tail = int'(length) - beat * 8;
        return (tail > 0 && tail < 8) ? low_bytes(tail) : keep_t'(8'hff);
    endfunction

    // first byte on the wire sits in bits 7:0
    function automatic data_word_t icmp_header_word(input row_t row);
        data_word_t w;
        w[7:0]   = row.icmp_type;
        w[15:8]  = row.icmp_code;
        w[23:16] = row.icmp_checksum[15:8];
        w[31:24] = row.icmp_checksum[7:0];
        w[39:32] = row.icmp_rest[31:24];
        w[47:40] = row.icmp_rest[23:16];
        w[55:48] = row.icmp_rest[15:8];
        w[63:56] = row.icmp_rest[7:0];
        return w;
    endfunction

    task automatic build_expected(input int r);
        int needed;
        int count;
        int tail;
        exp_data.delete();
        exp_keep.delete();
        exp_last.delete();
        exp_user.delete();
        needed = (int'(rows[r].length) + 7) / 8;
        count = (rows[r].n_beats < needed) ? rows[r].n_beats : needed;
        exp_errors = (rows[r].n_beats < needed) ? 1 : 0;
        exp_data.push_back(icmp_header_word(rows[r]));
        exp_keep.push_back(keep_t'(8'hff));
        exp_last.push_back(1'b0);
        exp_user.push_back(1'b0);
        for (int i = 0; i < count; i++) begin
            tail = int'(rows[r].length) - i * 8;
            exp_data.push_back(payload_word(r, i));
            exp_keep.push_back((tail < 8) ? low_bytes(tail) : keep_t'(8'hff));
            exp_last.push_back(i == count - 1);
            exp_user.push_back(i == count - 1 && exp_errors == 1);
        end
    endtask

    task automatic check_word(input string what, input data_word_t got_data,
                              input keep_t got_keep, input data_word_t want_data,
                              input keep_t want_keep);
        data_word_t mask;
        for (int b = 0; b < `KEEP_W; b++) begin
            mask[b*8 +: 8] = {8{want_keep[b]}};
        end
        if (got_keep !== want_keep) begin
            abort_run($sformatf("Error at time %0t: %s keep %h, expected %h",
                                $time, what, got_keep, want_keep));
        end
        // bytes outside the keep carry no payload
        if ((got_data & mask) !== (want_data & mask)) begin
            abort_run($sformatf("Error at time %0t: %s data %h, expected %h",
                                $time, what, got_data & mask, want_data & mask));
        end
    endtask

    task automatic check_hdr(input len_t want_len, input ip_addr_t want_src,
                             input ip_addr_t want_dst, input logic [15:0] want_id,
                             input logic [7:0] want_ttl);
        if (out_ip_length !== want_len) begin
            abort_run($sformatf("Error at time %0t: out_ip_length %0d, expected %0d",
                                $time, out_ip_length, want_len));
        end
        if (out_ip_source !== want_src || out_ip_dest !== want_dst) begin
            abort_run($sformatf("Error at time %0t: addresses %h %h, expected %h %h",
                                $time, out_ip_source, out_ip_dest, want_src, want_dst));
        end
        if (out_ip_identification !== want_id || out_ip_ttl !== want_ttl) begin
            abort_run($sformatf("Error at time %0t: id %h ttl %0d, expected %h %0d",
                                $time, out_ip_identification, out_ip_ttl, want_id, want_ttl));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("Error at time %0t: %s is %b, expected %b",
                                $time, what, got, want));
        end
    endtask

    task automatic send_header(input row_t row);
        @(negedge clk);
        icmp_type = row.icmp_type;
        icmp_code = row.icmp_code;
        icmp_checksum = row.icmp_checksum;
        icmp_rest = row.icmp_rest;
        icmp_length = row.length;
        ip_identification = row.ident;
        ip_ttl = row.ttl;
        ip_source = row.source;
        ip_dest = row.dest;
        hdr_valid = 1'b1;
        // ready seen here holds through the next rising edge
        while (!hdr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        hdr_valid = 1'b0;
        check_flag("out_hdr_valid after header transfer", out_hdr_valid, 1'b1);
        check_flag("busy after header transfer", busy, 1'b1);
    endtask

    task automatic send_payload(input int r);
        @(negedge clk);
        for (int i = 0; i < rows[r].n_beats; i++) begin
            in_data = payload_word(r, i);
            in_keep = input_keep(rows[r].length, i);
            in_last = (i == rows[r].n_beats - 1);
            in_valid = 1'b1;
            while (!in_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_last = 1'b0;
    endtask

    task automatic collect_output(input int r);
        int          beats_seen;
        int          hdrs_seen;
        int          errors_seen;
        int          idle_cycles;
        logic [31:0] rnd;
        string       beat_name;
        beats_seen = 0;
        hdrs_seen = 0;
        errors_seen = 0;
        idle_cycles = 0;
        // a few cycles past the frame to catch stray beats or pulses
        while (beats_seen < exp_data.size() || hdrs_seen == 0 || idle_cycles < 4) begin
            @(negedge clk);
            if (rows[r].stall) begin
                rnd = $random(seed);
                out_ready = rnd[0];
                out_hdr_ready = rnd[1];
            end else begin
                out_ready = 1'b1;
                out_hdr_ready = 1'b1;
            end
            if (early_end_error) begin
                errors_seen++;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (hdrs_seen != 0) begin
                    abort_run($sformatf("Error at time %0t: second header in row %0d",
                                        $time, r));
                end
                check_hdr(rows[r].length + 16'd28, rows[r].source, rows[r].dest,
                          rows[r].ident, rows[r].ttl);
                hdrs_seen++;
            end
            if (out_valid && out_ready) begin
                if (beats_seen >= exp_data.size()) begin
                    abort_run($sformatf("Error at time %0t: extra output beat in row %0d",
                                        $time, r));
                end
                beat_name = $sformatf("row %0d beat %0d", r, beats_seen);
                check_word(beat_name, out_data, out_keep,
                           exp_data[beats_seen], exp_keep[beats_seen]);
                check_flag({beat_name, " out_last"}, out_last, exp_last[beats_seen]);
                check_flag({beat_name, " out_user"}, out_user, exp_user[beats_seen]);
                beats_seen++;
            end
            if (beats_seen == exp_data.size() && hdrs_seen != 0) begin
                idle_cycles++;
            end
        end
        if (errors_seen != exp_errors) begin
            abort_run($sformatf("Error at time %0t: row %0d had %0d error pulses, expected %0d",
                                $time, r, errors_seen, exp_errors));
        end
    endtask

    // cycle budget scales with the table
    initial begin
        int budget;
        wait (table_ready);
        budget = 20;
        for (int r = 0; r < num_rows; r++) begin
            budget = budget + (rows[r].n_beats + 20) * 4;
        end
        repeat (budget) @(posedge clk);
        abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                            budget));
    end

    initial begin
        seed = 85502;
        hdr_valid = 1'b0;
        icmp_type = '0;
        icmp_code = '0;
        icmp_checksum = '0;
        icmp_rest = '0;
        icmp_length = '0;
        ip_identification = '0;
        ip_ttl = '0;
        ip_source = '0;
        ip_dest = '0;
        in_data = '0;
        in_keep = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
        out_hdr_ready = 1'b0;
        out_ready = 1'b0;
        fill_table();
        table_ready = 1'b1;
        wait (rst === 1'b0);
        check_flag("hdr_ready at reset release", hdr_ready, 1'b0);
        check_flag("in_ready at reset release", in_ready, 1'b0);
        check_flag("out_hdr_valid at reset release", out_hdr_valid, 1'b0);
        check_flag("out_valid at reset release", out_valid, 1'b0);
        check_flag("busy at reset release", busy, 1'b0);
        check_flag("early_end_error at reset release", early_end_error, 1'b0);
        for (int r = 0; r < num_rows; r++) begin
            build_expected(r);
            fork
                send_header(rows[r]);
                send_payload(r);
                collect_output(r);
            join
            check_flag("busy after frame", busy, 1'b0);
            check_flag("hdr_ready after frame", hdr_ready, 1'b1);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
verilog/icmp_tx_pkg.sv
verilog/icmp_hdr_regs.sv
verilog/icmp_tx_fsm.sv
verilog/axis_out_buffer.sv
verilog/icmp_tx_top.sv
testbench/tb_clock_gen.sv
testbench/tb_icmp_tx.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing -j 0 --timescale 1ns/1ns
TOP       := tb_icmp_tx
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
